/* fetch_consts.svh */
//////////////////////////////
// sizes and APB register offsets for the fetch path.
// include in any file that needs them.
//////////////////////////////
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

`define FETCH_BUF_DEPTH  8      // halfword entries, power of two, at least 4.
`define FETCH_HALF_WIDTH 16
`define FETCH_WORD_WIDTH 32

`define FETCH_REG_CTRL   4'h0   // flush pulse and fetch enable.
`define FETCH_REG_STATUS 4'h4   // entry counts.
`define FETCH_REG_CCOUNT 4'h8   // compressed instructions delivered.
`define FETCH_REG_FCOUNT 4'hc   // full instructions delivered.

`endif

/* fetch_pkg.sv */
//////////////////////////////
// shared types of the fetch path.
// referenced by scoped name.
//////////////////////////////
`include "fetch_consts.svh"

package fetch_pkg;

    typedef logic [`FETCH_HALF_WIDTH-1:0] halfword_t;       // one buffer entry.

    typedef logic [$clog2(`FETCH_BUF_DEPTH):0] entry_count_t;  // 0 up to full.

    typedef struct packed {
        halfword_t high;
        halfword_t low;
    } halfword_pair_t;

    // an instruction or fetch word, seen whole or as two halfwords
    typedef union packed {
        logic [`FETCH_WORD_WIDTH-1:0] word;
        halfword_pair_t               half;
    } insn_word_t;

    typedef logic [3:0] reg_addr_t;   // byte offset inside the register block.

endpackage

/* insn_buffer.sv */
//////////////////////////////
// circular halfword buffer, two writes and two reads per cycle.
//////////////////////////////
`timescale 1ns/100ps
`include "fetch_consts.svh"

module insn_buffer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    write_low,
    input  logic                    write_high,
    input  fetch_pkg::halfword_t    write_entry_low,
    input  fetch_pkg::halfword_t    write_entry_high,
    input  logic                    read_low,
    input  logic                    read_high,
    output fetch_pkg::halfword_t    read_entry_low,
    output fetch_pkg::halfword_t    read_entry_high,
    output fetch_pkg::entry_count_t readable_count,
    output fetch_pkg::entry_count_t writable_count
);
    localparam int DEPTH = `FETCH_BUF_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    typedef logic [IDX_W-1:0] index_t;

    typedef enum logic [1:0] {
        SRC_KEEP,
        SRC_LOW,
        SRC_HIGH
    } src_t;

    fetch_pkg::halfword_t    entries [DEPTH];
    src_t                    src [DEPTH];
    index_t                  head;
    index_t                  tail;
    index_t                  head_next_slot;
    index_t                  tail_next_slot;
    fetch_pkg::entry_count_t readable_reg;
    fetch_pkg::entry_count_t writable_reg;
    fetch_pkg::entry_count_t read_num;
    fetch_pkg::entry_count_t write_num;

    always_comb begin
        read_num  = fetch_pkg::entry_count_t'(read_low) + fetch_pkg::entry_count_t'(read_high);
        write_num = fetch_pkg::entry_count_t'(write_low) + fetch_pkg::entry_count_t'(write_high);
        head_next_slot = head + index_t'(1);
        tail_next_slot = tail + index_t'(1);
    end

    // high half lands at tail when it is written alone
    always_comb begin
        index_t idx;
        for (int i = 0; i < DEPTH; i++) begin
            idx = index_t'(i);
            if (write_low && idx == tail) begin
                src[i] = SRC_LOW;
            end else if (write_high && !write_low && idx == tail) begin
                src[i] = SRC_HIGH;
            end else if (write_high && write_low && idx == tail_next_slot) begin
                src[i] = SRC_HIGH;
            end else begin
                src[i] = SRC_KEEP;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (src[i] == SRC_LOW) begin
                entries[i] <= write_entry_low;
            end else if (src[i] == SRC_HIGH) begin
                entries[i] <= write_entry_high;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head         <= '0;
            tail         <= '0;
            readable_reg <= '0;
            writable_reg <= fetch_pkg::entry_count_t'(DEPTH);  // empty.
        end else begin
            head         <= head + read_num[IDX_W-1:0];
            tail         <= tail + write_num[IDX_W-1:0];
            readable_reg <= readable_reg - read_num + write_num;
            writable_reg <= writable_reg + read_num - write_num;
        end
    end

    assign read_entry_low  = entries[head];
    assign read_entry_high = entries[head_next_slot];
    assign readable_count  = readable_reg;
    assign writable_count  = writable_reg;

    // writer and aligner must respect the counts
    assert property (@(posedge clk) disable iff (reset || flush)
        write_num <= writable_reg);
    assert property (@(posedge clk) disable iff (reset || flush)
        read_num <= readable_reg);
    assert property (@(posedge clk) disable iff (reset || flush)
        read_high |-> read_low);

endmodule

/* fetch_writer.sv */
//////////////////////////////
// one-word skid register in front of the buffer.
//////////////////////////////
`timescale 1ns/100ps

module fetch_writer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    fetch_enable,
    input  logic                    fetch_valid,
    output logic                    fetch_ready,
    input  fetch_pkg::insn_word_t   fetch_word,
    input  logic                    fetch_offset,
    input  fetch_pkg::entry_count_t writable_count,
    output logic                    write_low,
    output logic                    write_high,
    output fetch_pkg::halfword_t    write_entry_low,
    output fetch_pkg::halfword_t    write_entry_high
);
    logic                  held_valid;
    logic                  held_offset;
    fetch_pkg::insn_word_t held_word;
    logic                  drain;

    assign fetch_ready = !held_valid && fetch_enable;
    assign drain       = held_valid && (writable_count >= 2);  // room for a whole word.

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            held_valid <= 1'b0;
        end else if (fetch_valid && fetch_ready) begin
            held_valid <= 1'b1;
        end else if (drain) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && fetch_ready) begin
            held_word   <= fetch_word;
            held_offset <= fetch_offset;
        end
    end

    assign write_low        = drain && !held_offset;  // odd start skips the low half.
    assign write_high       = drain;
    assign write_entry_low  = held_word.half.low;
    assign write_entry_high = held_word.half.high;

endmodule

/* insn_aligner.sv */
//////////////////////////////
// forms one instruction from the buffer head.
//////////////////////////////
`timescale 1ns/100ps

module insn_aligner (
    input  fetch_pkg::halfword_t    read_entry_low,
    input  fetch_pkg::halfword_t    read_entry_high,
    input  fetch_pkg::entry_count_t readable_count,
    output logic                    read_low,
    output logic                    read_high,
    output logic                    insn_valid,
    input  logic                    insn_ready,
    output fetch_pkg::insn_word_t   insn,
    output logic                    insn_compressed
);
    logic                  is_full;
    logic                  accept;
    fetch_pkg::insn_word_t joined;

    // RVC encodes length in the two lowest bits
    assign is_full = (read_entry_low[1:0] == 2'b11);

    always_comb begin
        if (is_full) begin
            insn_valid = (readable_count >= 2);  // both halves present.
        end else begin
            insn_valid = (readable_count >= 1);
        end
    end

    always_comb begin
        joined.half.low  = read_entry_low;
        joined.half.high = is_full ? read_entry_high : '0;  // zero-extend rvc.
    end

    assign insn.word       = joined.word;
    assign insn_compressed = !is_full;

    assign accept    = insn_valid && insn_ready;
    assign read_low  = accept;
    assign read_high = accept && is_full;

endmodule

/* fetch_regs.sv */
//////////////////////////////
// APB control, status and counter registers.
// drives flush and fetch enable.
//////////////////////////////
`timescale 1ns/100ps
`include "fetch_consts.svh"

module fetch_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [3:0]              paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  fetch_pkg::entry_count_t readable_count,
    input  fetch_pkg::entry_count_t writable_count,
    input  logic                    insn_valid,
    input  logic                    insn_ready,
    input  logic                    insn_compressed,
    output logic                    flush,
    output logic                    fetch_enable
);
    fetch_pkg::reg_addr_t addr;
    logic                 mapped;
    logic                 wr;
    logic                 delivered;
    logic [31:0]          ccount;
    logic [31:0]          fcount;

    assign addr   = paddr;
    assign mapped = (addr == `FETCH_REG_CTRL) || (addr == `FETCH_REG_STATUS) ||
                    (addr == `FETCH_REG_CCOUNT) || (addr == `FETCH_REG_FCOUNT);
    assign wr     = psel && penable && pwrite && mapped;  // access phase write.

    assign pready  = 1'b1;
    assign pslverr = psel && penable && !mapped;

    assign delivered = insn_valid && insn_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            flush        <= 1'b0;
            fetch_enable <= 1'b0;
        end else begin
            flush <= wr && (addr == `FETCH_REG_CTRL) && pwdata[0];  // single cycle.
            if (wr && addr == `FETCH_REG_CTRL) begin
                fetch_enable <= pwdata[1];
            end
        end
    end

    // a write clears a counter, even on a delivery cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            ccount <= '0;
            fcount <= '0;
        end else begin
            if (wr && addr == `FETCH_REG_CCOUNT) begin
                ccount <= '0;
            end else if (delivered && insn_compressed) begin
                ccount <= ccount + 32'd1;
            end
            if (wr && addr == `FETCH_REG_FCOUNT) begin
                fcount <= '0;
            end else if (delivered && !insn_compressed) begin
                fcount <= fcount + 32'd1;
            end
        end
    end

    always_comb begin
        case (addr)
            `FETCH_REG_CTRL:   prdata = {30'd0, fetch_enable, 1'b0};  // flush reads 0.
            `FETCH_REG_STATUS: prdata = {16'd0, 8'(writable_count), 8'(readable_count)};
            `FETCH_REG_CCOUNT: prdata = ccount;
            `FETCH_REG_FCOUNT: prdata = fcount;
            default:           prdata = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (reset)
        penable |-> psel);

endmodule

/* insn_fetch_path.sv */
//////////////////////////////
// fetch-to-decode path top level.
//////////////////////////////
`timescale 1ns/100ps

module insn_fetch_path (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fetch_valid,
    output logic                  fetch_ready,
    input  fetch_pkg::insn_word_t fetch_word,
    input  logic                  fetch_offset,
    output logic                  insn_valid,
    input  logic                  insn_ready,
    output fetch_pkg::insn_word_t insn,
    output logic                  insn_compressed,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [3:0]            paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr
);
    logic                    flush;
    logic                    fetch_enable;
    logic                    write_low;
    logic                    write_high;
    fetch_pkg::halfword_t    write_entry_low;
    fetch_pkg::halfword_t    write_entry_high;
    logic                    read_low;
    logic                    read_high;
    fetch_pkg::halfword_t    read_entry_low;
    fetch_pkg::halfword_t    read_entry_high;
    fetch_pkg::entry_count_t readable_count;
    fetch_pkg::entry_count_t writable_count;

    fetch_regs fetch_regs_inst (
        .clk             (clk),
        .reset           (reset),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .readable_count  (readable_count),
        .writable_count  (writable_count),
        .insn_valid      (insn_valid),
        .insn_ready      (insn_ready),
        .insn_compressed (insn_compressed),
        .flush           (flush),
        .fetch_enable    (fetch_enable)
    );

    fetch_writer fetch_writer_inst (
        .clk              (clk),
        .reset            (reset),
        .flush            (flush),
        .fetch_enable     (fetch_enable),
        .fetch_valid      (fetch_valid),
        .fetch_ready      (fetch_ready),
        .fetch_word       (fetch_word),
        .fetch_offset     (fetch_offset),
        .writable_count   (writable_count),
        .write_low        (write_low),
        .write_high       (write_high),
        .write_entry_low  (write_entry_low),
        .write_entry_high (write_entry_high)
    );

    insn_buffer insn_buffer_inst (
        .clk              (clk),
        .reset            (reset),
        .flush            (flush),
        .write_low        (write_low),
        .write_high       (write_high),
        .write_entry_low  (write_entry_low),
        .write_entry_high (write_entry_high),
        .read_low         (read_low),
        .read_high        (read_high),
        .read_entry_low   (read_entry_low),
        .read_entry_high  (read_entry_high),
        .readable_count   (readable_count),
        .writable_count   (writable_count)
    );

    insn_aligner insn_aligner_inst (
        .read_entry_low  (read_entry_low),
        .read_entry_high (read_entry_high),
        .readable_count  (readable_count),
        .read_low        (read_low),
        .read_high       (read_high),
        .insn_valid      (insn_valid),
        .insn_ready      (insn_ready),
        .insn            (insn),
        .insn_compressed (insn_compressed)
    );

endmodule

/* tb_insn_fetch_path.sv */
//////////////////////////////
// self-checking testbench for the fetch path.
// stimulus and expected words come from insn_patterns.txt.
//////////////////////////////
`timescale 1ns/100ps
`include "fetch_consts.svh"

module tb_insn_fetch_path;

    localparam int CLK_PERIOD   = 100;
    localparam int MAX_PATTERNS = 64;

    logic        clk;
    logic        reset;
    logic        fetch_valid;
    logic        fetch_ready;
    logic [31:0] fetch_word;
    logic        fetch_offset;
    logic        insn_valid;
    logic        insn_ready;
    logic [31:0] insn;
    logic        insn_compressed;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [35:0] pattern_mem [MAX_PATTERNS];   // tag nibble over a 32-bit word.
    logic [31:0] fetch_words [$];
    logic        fetch_offsets [$];
    logic [31:0] expected [$];
    int          pattern_count;
    bit          loaded;
    int          seed = 51228;
    int          error_count;
    int          check_count;
    int          test_count;
    int          errors_at_start;
    string       test_name;
    int          seen_compressed;
    int          seen_full;

    insn_fetch_path insn_fetch_path_inst (
        .clk             (clk),
        .reset           (reset),
        .fetch_valid     (fetch_valid),
        .fetch_ready     (fetch_ready),
        .fetch_word      (fetch_word),
        .fetch_offset    (fetch_offset),
        .insn_valid      (insn_valid),
        .insn_ready      (insn_ready),
        .insn            (insn),
        .insn_compressed (insn_compressed),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // budget of 40 cycles per pattern line.
    initial begin
        wait (loaded);
        #((pattern_count * 40 + 200) * CLK_PERIOD);
        $display("watchdog expired, a stream or handshake never completed");
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic check_equal(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        assert (act === exp) else begin
            $display("FAILED %s (%s) expected %h actual %h", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        test_count++;
        $display("test %-14s %s", test_name, (error_count == errors_at_start) ? "ok" : "failed");
    endtask

    task automatic load_patterns();
        $readmemh("insn_patterns.txt", pattern_mem);
        pattern_count = 0;
        while (pattern_count < MAX_PATTERNS && pattern_mem[pattern_count][35:32] != 4'hf) begin
            if (pattern_mem[pattern_count][35:32] == 4'h2) begin
                expected.push_back(pattern_mem[pattern_count][31:0]);
            end else begin
                fetch_words.push_back(pattern_mem[pattern_count][31:0]);
                fetch_offsets.push_back(pattern_mem[pattern_count][32]);
            end
            pattern_count++;
        end
        loaded = 1'b1;
    endtask

    // one APB transfer, sampled mid-way through the access phase
    task automatic apb_access(input logic write, input logic [3:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata,
                              output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        rdata = prdata;
        err   = pslverr;
        check_equal("pready", 32'd1, 32'(pready));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_equal("pslverr on write", 32'd0, 32'(err));
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
        check_equal("pslverr on read", 32'd0, 32'(err));
    endtask

    task automatic drive_fetches(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            @(negedge clk);
            fetch_valid  = 1'b1;
            fetch_word   = fetch_words[i];
            fetch_offset = fetch_offsets[i];
            while (!fetch_ready) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    task automatic collect_insns(input int first, input int last, input bit random_ready);
        int idx;
        idx = first;
        while (idx <= last) begin
            @(negedge clk);
            insn_ready = random_ready ? 1'($random(seed)) : 1'b1;
            if (insn_valid && insn_ready) begin
                check_equal("instruction", expected[idx], insn);
                check_equal("compressed flag", 32'(expected[idx][1:0] != 2'b11),
                            32'(insn_compressed));
                if (expected[idx][1:0] != 2'b11) begin
                    seen_compressed++;
                end else begin
                    seen_full++;
                end
                idx++;
            end
        end
        @(negedge clk);
        insn_ready = 1'b0;
    endtask

    // compare both counters with the stream, then clear them
    task automatic check_counters();
        logic [31:0] data;
        read_reg(`FETCH_REG_CCOUNT, data);
        check_equal("ccount", 32'(seen_compressed), data);
        read_reg(`FETCH_REG_FCOUNT, data);
        check_equal("fcount", 32'(seen_full), data);
        write_reg(`FETCH_REG_CCOUNT, 32'd0);
        write_reg(`FETCH_REG_FCOUNT, 32'd0);
        read_reg(`FETCH_REG_CCOUNT, data);
        check_equal("ccount cleared", 32'd0, data);
        read_reg(`FETCH_REG_FCOUNT, data);
        check_equal("fcount cleared", 32'd0, data);
        seen_compressed = 0;
        seen_full       = 0;
    endtask

    initial begin
        logic [31:0] data;
        logic        err;
        int          queued;
        reset        = 1'b1;
        fetch_valid  = 1'b0;
        fetch_word   = 32'd0;
        fetch_offset = 1'b0;
        insn_ready   = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = 4'd0;
        pwdata       = 32'd0;
        load_patterns();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // mixed lengths, straddles and an odd first fetch
        start_test("alignment");
        write_reg(`FETCH_REG_CTRL, 32'h2);
        fork
            drive_fetches(0, fetch_words.size() - 1);
            collect_insns(0, expected.size() - 1, 1'b0);
        join
        check_counters();
        end_test();

        start_test("backpressure");
        fork
            drive_fetches(0, fetch_words.size() - 1);
            begin
                insn_ready = 1'b0;
                repeat (30) @(negedge clk);   // buffer and skid fill up.
                repeat (16) begin
                    @(negedge clk);
                    check_equal("fetch_ready while stalled", 32'd0, 32'(fetch_ready));
                end
                collect_insns(0, expected.size() - 1, 1'b1);
            end
        join
        check_counters();
        end_test();

        start_test("flush");
        drive_fetches(0, 2);
        queued = 0;
        for (int i = 0; i <= 2; i++) begin
            queued += fetch_offsets[i] ? 1 : 2;   // odd start adds one halfword.
        end
        read_reg(`FETCH_REG_STATUS, data);
        check_equal("readable before flush", 32'(queued), {24'd0, data[7:0]});
        write_reg(`FETCH_REG_CTRL, 32'h3);
        read_reg(`FETCH_REG_STATUS, data);
        check_equal("readable after flush", 32'd0, {24'd0, data[7:0]});
        check_equal("writable after flush", 32'(`FETCH_BUF_DEPTH), {24'd0, data[15:8]});
        // record 1 is the first even-aligned fetch and opens instruction 1
        fork
            drive_fetches(1, fetch_words.size() - 1);
            collect_insns(1, expected.size() - 1, 1'b0);
        join
        check_counters();
        end_test();

        start_test("enable_error");
        write_reg(`FETCH_REG_CTRL, 32'h0);
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch_word  = fetch_words[1];
        repeat (10) begin
            @(negedge clk);
            check_equal("fetch_ready while disabled", 32'd0, 32'(fetch_ready));
        end
        fetch_valid = 1'b0;
        apb_access(1'b0, 4'h2, 32'd0, data, err);
        check_equal("pslverr on unmapped read", 32'd1, 32'(err));
        apb_access(1'b1, 4'h6, 32'h1, data, err);
        check_equal("pslverr on unmapped write", 32'd1, 32'(err));
        end_test();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* insn_patterns.txt */
// tag then word: tag 0 fetch at offset 0, tag 1 fetch at offset 1,
// tag 2 expected instruction in delivery order, tag f end of data.
14501dead
005138082
0418500a5
000b50533
011414681
000100293
00e130002
080820070
200004501
200008082
200a50513
200004185
200b50533
200004681
200001141
200100293
200000002
200700e13
200008082
f00000000

/* verilog.f */
+incdir+.
fetch_pkg.sv
insn_buffer.sv
fetch_writer.sv
insn_aligner.sv
fetch_regs.sv
insn_fetch_path.sv
tb_insn_fetch_path.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_insn_fetch_path
FILELIST  = verilog.f
PASS_MSG  = TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
